//--- all.f
afe_pkg.sv
hk_bus_pkg.sv
hk_regs.sv
adc_frontend.sv
dac_mixer.sv
dac_interleave.sv
afe_top.sv
tb_clock_gen.sv
afe_top_assertions.sv
afe_top_tb.sv

//--- run.sh
#!/bin/sh
# Build the AFE testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module afe_top_tb -f all.f -o afe_sim
if [ $? -ne 0 ]; then
  echo "run.sh: Verilator build failed"
  exit 1
fi

./obj_dir/afe_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "run.sh: simulation exited with status $status"
  exit 1
fi

if grep -q "^Everything OK$" sim.log; then
  echo "run.sh: PASS"
  exit 0
else
  echo "run.sh: FAIL"
  exit 1
fi

//--- afe_top_tb.sv
//////////////////////////////////////////////////////////////////////
// AFE testbench driving random streams and bus accesses against a model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module afe_top_tb;

localparam int CH_N     = afe_pkg::CH_N_DEF;
localparam int SMP_MAX  = (1 << (afe_pkg::SMP_W - 1)) - 1;
localparam int SMP_MIN  = -(1 << (afe_pkg::SMP_W - 1));
localparam int ADC_CYC  = 500;
localparam int DAC_CYC  = 800;
localparam int LOOP_CYC = 200;
localparam int TIMEOUT  = 3000;  // tests take about 1700 cycles

logic                                    clk;
logic                                    rst;
logic                                    wb_cyc;
logic                                    wb_stb;
logic                                    wb_we;
logic [hk_bus_pkg::WB_AW-1:0]            wb_adr;
logic [hk_bus_pkg::WB_DW-1:0]            wb_wdat;
logic [hk_bus_pkg::WB_DW-1:0]            wb_rdat;
logic                                    wb_ack;
logic                                    wb_err;
logic [CH_N-1:0][afe_pkg::ADC_RAW_W-1:0] adc_dat;
afe_pkg::smp_t [CH_N-1:0]                adc_out;
afe_pkg::smp_t [CH_N-1:0]                asg_dat;
afe_pkg::smp_t [CH_N-1:0]                pid_dat;
logic [afe_pkg::SMP_W-1:0]               dac_dat;
logic                                    dac_sel;
logic                                    dac_rst;

// Reference model state
integer                                  seed;
logic [CH_N-1:0][afe_pkg::ADC_RAW_W-1:0] adc_prev;   // word of the last cycle
afe_pkg::smp_t [CH_N-1:0]                mix_d1;     // mix one cycle back
afe_pkg::smp_t [CH_N-1:0]                mix_d2;     // mix two cycles back
int                                      sat_model;  // clamped channel-samples
bit                                      loop_on;
int                                      cyc_cnt = 0;

tb_clock_gen #(.PERIOD_NS (8), .RST_CYCLES (8)) tb_clock_gen_i (
  .clk_o (clk),
  .rst_o (rst)
);

afe_top #(.CH_N (CH_N)) afe_top_i (
  .dac_clk_1x (clk    ),
  .rst_i      (rst    ),
  .wb_cyc_i   (wb_cyc ),
  .wb_stb_i   (wb_stb ),
  .wb_we_i    (wb_we  ),
  .wb_adr_i   (wb_adr ),
  .wb_dat_i   (wb_wdat),
  .wb_dat_o   (wb_rdat),
  .wb_ack_o   (wb_ack ),
  .wb_err_o   (wb_err ),
  .adc_dat_i  (adc_dat),
  .adc_dat_o  (adc_out),
  .asg_dat_i  (asg_dat),
  .pid_dat_i  (pid_dat),
  .dac_dat_o  (dac_dat),
  .dac_sel_o  (dac_sel),
  .dac_rst_o  (dac_rst)
);

bind afe_top afe_top_assertions afe_top_assertions_i (
  .dac_clk_1x (dac_clk_1x),
  .rst_i      (rst_i     ),
  .ack_i      (wb_ack_o  ),
  .err_i      (wb_err_o  ),
  .sel_i      (dac_sel_o )
);

//////////////////////////////////////////////////////////////////////
// Model functions
//////////////////////////////////////////////////////////////////////

// Negative slope code gives sample = 8191 - code modulo 2^14
function automatic afe_pkg::smp_t adc_model(input logic [afe_pkg::ADC_RAW_W-1:0] w);
  logic [31:0] v;
  v = SMP_MAX - int'(w[afe_pkg::ADC_RAW_W-1:2]);  // two LSBs dropped
  return afe_pkg::smp_t'(v[afe_pkg::SMP_W-1:0]);
endfunction

// Same mapping back towards the DAC
function automatic logic [afe_pkg::SMP_W-1:0] dac_code(input afe_pkg::smp_t s);
  logic [31:0] v;
  v = SMP_MAX - int'(s);
  return v[afe_pkg::SMP_W-1:0];
endfunction

function automatic afe_pkg::smp_t sat_sum(input afe_pkg::smp_t a, input afe_pkg::smp_t b,
                                          output logic clamped);
  int s;
  s = int'(a) + int'(b);
  clamped = (s > SMP_MAX) || (s < SMP_MIN);
  if (s > SMP_MAX)
    s = SMP_MAX;
  else if (s < SMP_MIN)
    s = SMP_MIN;
  return afe_pkg::smp_t'(s);
endfunction

task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
  if (got !== exp) begin
    $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
    $display("Something failed");
    $fatal(1);
  end
endtask

//////////////////////////////////////////////////////////////////////
// Bus and stream tasks
//////////////////////////////////////////////////////////////////////

task automatic bus_access(input logic we, input logic [hk_bus_pkg::WB_AW-1:0] adr,
                          input logic [hk_bus_pkg::WB_DW-1:0] wdat,
                          output logic [hk_bus_pkg::WB_DW-1:0] rdat, output logic err);
  @(posedge clk);
  wb_cyc  <= 1'b1;
  wb_stb  <= 1'b1;
  wb_we   <= we;
  wb_adr  <= adr;
  wb_wdat <= wdat;
  do
    @(negedge clk);  // held until ack or err
  while (!(wb_ack || wb_err));
  rdat = wb_rdat;
  err  = wb_err;
  @(posedge clk);
  wb_cyc <= 1'b0;
  wb_stb <= 1'b0;
  wb_we  <= 1'b0;
  mix_d2 = mix_d1;   // Streams held so the DAC pipe is full of the last mix
endtask

task automatic reg_read(input logic [hk_bus_pkg::WB_AW-1:0] adr,
                        output logic [hk_bus_pkg::WB_DW-1:0] dat);
  logic err;
  bus_access(1'b0, adr, '0, dat, err);
  check_eq({31'd0, err}, 32'd0, "read answered with err");
endtask

task automatic reg_write(input logic [hk_bus_pkg::WB_AW-1:0] adr,
                         input logic [hk_bus_pkg::WB_DW-1:0] dat);
  logic [hk_bus_pkg::WB_DW-1:0] rd;
  logic                         err;
  bus_access(1'b1, adr, dat, rd, err);
  check_eq({31'd0, err}, 32'd0, "write answered with err");
endtask

// One sample per channel in with ADC and DAC outputs checked at negedge
task automatic run_cycle(input bit streams_on);
  logic [31:0]                             r;
  logic                                    clamped;
  logic [CH_N-1:0][afe_pkg::ADC_RAW_W-1:0] w;
  afe_pkg::smp_t [CH_N-1:0]                a;
  afe_pkg::smp_t [CH_N-1:0]                p;
  afe_pkg::smp_t [CH_N-1:0]                m;
  logic [afe_pkg::SMP_W-1:0]               dac_exp;
  @(posedge clk);
  for (int ch = 0; ch < CH_N; ch++) begin
    r     = $random(seed);
    w[ch] = r[15:0];
    r     = $random(seed);
    a[ch] = streams_on ? r[13:0] : '0;  // uniform pair overflows a quarter of the time
    r     = $random(seed);
    p[ch] = streams_on ? r[13:0] : '0;
    m[ch] = sat_sum(a[ch], p[ch], clamped);
    if (clamped)
      sat_model++;
  end
  adc_dat <= w;
  asg_dat <= a;
  pid_dat <= p;
  @(negedge clk);
  for (int ch = 0; ch < CH_N; ch++) begin
    if (loop_on)
      check_eq({18'd0, adc_out[ch]}, {18'd0, m[ch]}, "loopback sample");
    else
      check_eq({18'd0, adc_out[ch]}, {18'd0, adc_model(adc_prev[ch])}, "ADC sample");
  end
  // Bus carries the channel named by sel
  dac_exp = dac_sel ? dac_code(mix_d2[1]) : dac_code(mix_d2[0]);
  check_eq({18'd0, dac_dat}, {18'd0, dac_exp}, "DAC bus word");
  adc_prev = w;
  mix_d2   = mix_d1;
  mix_d1   = m;
endtask

// Watchdog
always @(posedge clk) begin
  cyc_cnt <= cyc_cnt + 1;
  if (cyc_cnt >= TIMEOUT) begin
    $display("timeout, run did not finish within %0d cycles", TIMEOUT);
    $display("Something failed");
    $fatal(1);
  end
end

//////////////////////////////////////////////////////////////////////
// Test sequence
//////////////////////////////////////////////////////////////////////

initial begin
  logic [hk_bus_pkg::WB_DW-1:0] rd;
  logic                         err;
  seed      = 32'ha3d3c62d;
  wb_cyc    = 1'b0;
  wb_stb    = 1'b0;
  wb_we     = 1'b0;
  wb_adr    = '0;
  wb_wdat   = '0;
  adc_dat   = '0;
  asg_dat   = '0;
  pid_dat   = '0;
  adc_prev  = '0;
  mix_d1    = '0;
  mix_d2    = '0;
  sat_model = 0;
  loop_on   = 1'b0;

  // Outputs held in reset
  @(negedge clk);
  check_eq({31'd0, dac_rst}, 32'd1, "DAC reset during reset");
  check_eq({31'd0, dac_sel}, 32'd0, "DAC select during reset");
  check_eq({18'd0, dac_dat}, 32'd0, "DAC bus during reset");
  check_eq({31'd0, wb_ack | wb_err}, 32'd0, "bus answer during reset");
  wait (rst === 1'b0);
  @(negedge clk);
  check_eq({31'd0, dac_rst}, 32'd1, "DAC reset one cycle after release");
  @(negedge clk);
  check_eq({31'd0, dac_rst}, 32'd0, "DAC reset after release");

  // 1. Register map after reset
  reg_read(hk_bus_pkg::REG_ID, rd);
  check_eq(rd, hk_bus_pkg::ID_VALUE, "ID register");
  reg_read(hk_bus_pkg::REG_CTRL, rd);
  check_eq(rd, 32'd0, "CTRL after reset");
  reg_read(hk_bus_pkg::REG_SAT_CNT, rd);
  check_eq(rd, 32'd0, "SAT_CNT after reset");
  bus_access(1'b0, 4'hC, '0, rd, err);
  check_eq({31'd0, err}, 32'd1, "err on unmapped address");
  reg_write(hk_bus_pkg::REG_ID, 32'h1234_5678);  // ignored
  reg_read(hk_bus_pkg::REG_ID, rd);
  check_eq(rd, hk_bus_pkg::ID_VALUE, "ID after write");

  // 2. ADC conversion with streams idle
  repeat (ADC_CYC) run_cycle(1'b0);

  // 3. DAC path with overflow
  repeat (DAC_CYC) run_cycle(1'b1);
  run_cycle(1'b0);  // quiet streams before the count is read

  // 4. Saturation counter and clear on write
  reg_read(hk_bus_pkg::REG_SAT_CNT, rd);
  check_eq(rd, sat_model, "SAT_CNT after DAC test");
  reg_write(hk_bus_pkg::REG_SAT_CNT, 32'h5A5A_0F0F);
  sat_model = 0;
  reg_read(hk_bus_pkg::REG_SAT_CNT, rd);
  check_eq(rd, 32'd0, "SAT_CNT after clear");

  // 5. Loopback on and then back to the pins
  reg_write(hk_bus_pkg::REG_CTRL, 32'hFFFF_FFFF);
  reg_read(hk_bus_pkg::REG_CTRL, rd);
  check_eq(rd, 32'd1, "CTRL loop bit");
  loop_on = 1'b1;
  repeat (LOOP_CYC) run_cycle(1'b1);
  reg_write(hk_bus_pkg::REG_CTRL, 32'd0);
  loop_on = 1'b0;
  repeat (LOOP_CYC / 2) run_cycle(1'b1);

  $display("Everything OK");
  $finish;
end

endmodule

//--- afe_top_assertions.sv
//////////////////////////////////////////////////////////////////////
// Wishbone answer and DAC select protocol rules, bound into afe_top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module afe_top_assertions (
  input logic dac_clk_1x,
  input logic rst_i,
  input logic ack_i,   // slave ack
  input logic err_i,   // slave err
  input logic sel_i    // DAC channel select
);

// Answer is ack or err, never both
ack_err_excl: assert property (@(posedge dac_clk_1x) disable iff (rst_i)
  !(ack_i && err_i))
  else $error("wb ack and err high in the same cycle");

// Single-cycle answer pulse
answer_pulse: assert property (@(posedge dac_clk_1x) disable iff (rst_i)
  (ack_i || err_i) |=> !(ack_i || err_i))
  else $error("wb answer held for more than one cycle");

// First edge after reset keeps the reset value of sel
sel_toggle: assert property (@(posedge dac_clk_1x) disable iff (rst_i)
  !$past(rst_i) |-> (sel_i != $past(sel_i)))
  else $error("dac select did not toggle");

endmodule

//--- tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock and power-on reset for the AFE simulation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 8
)(
  output logic clk_o,
  output logic rst_o
);

initial clk_o = 1'b0;
always #(PERIOD_NS / 2) clk_o = ~clk_o;  // free running

// Reset released on a rising edge
initial begin
  rst_o = 1'b1;
  repeat (RST_CYCLES) @(posedge clk_o);
  rst_o <= 1'b0;
end

endmodule

//--- afe_top.sv
//////////////////////////////////////////////////////////////////////
// Analog front-end datapath top, ADC and DAC formatting with the
// housekeeping register block, instantiated by the board top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module afe_top #(
  parameter int CH_N = afe_pkg::CH_N_DEF
)(
  input  logic                                     dac_clk_1x,
  input  logic                                     rst_i,
  // Wishbone slave
  input  logic                                     wb_cyc_i,
  input  logic                                     wb_stb_i,
  input  logic                                     wb_we_i,
  input  logic [hk_bus_pkg::WB_AW-1:0]             wb_adr_i,
  input  logic [hk_bus_pkg::WB_DW-1:0]             wb_dat_i,
  output logic [hk_bus_pkg::WB_DW-1:0]             wb_dat_o,
  output logic                                     wb_ack_o,
  output logic                                     wb_err_o,
  // ADC
  input  logic [CH_N-1:0][afe_pkg::ADC_RAW_W-1:0]  adc_dat_i,
  output afe_pkg::smp_t [CH_N-1:0]                 adc_dat_o,
  // Streams from generator and controller
  input  afe_pkg::smp_t [CH_N-1:0]                 asg_dat_i,
  input  afe_pkg::smp_t [CH_N-1:0]                 pid_dat_i,
  // DAC
  output logic [afe_pkg::SMP_W-1:0]                dac_dat_o,
  output logic                                     dac_sel_o,
  output logic                                     dac_rst_o
);

afe_pkg::smp_t [CH_N-1:0] mix_dat;       // saturated sums
logic [CH_N-1:0]          sat_flag;
logic                     digital_loop;

//////////////////////////////////////////////////////////////////////
// Housekeeping
//////////////////////////////////////////////////////////////////////

hk_regs #(.CH_N (CH_N)) hk_regs_i (
  .dac_clk_1x     (dac_clk_1x  ),
  .rst_i          (rst_i       ),
  .wb_cyc_i       (wb_cyc_i    ),
  .wb_stb_i       (wb_stb_i    ),
  .wb_we_i        (wb_we_i     ),
  .wb_adr_i       (wb_adr_i    ),
  .wb_dat_i       (wb_dat_i    ),
  .wb_dat_o       (wb_dat_o    ),
  .wb_ack_o       (wb_ack_o    ),
  .wb_err_o       (wb_err_o    ),
  .sat_flag_i     (sat_flag    ),
  .digital_loop_o (digital_loop)
);

//////////////////////////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////////////////////////

adc_frontend #(.CH_N (CH_N)) adc_frontend_i (
  .dac_clk_1x     (dac_clk_1x  ),
  .rst_i          (rst_i       ),
  .adc_dat_i      (adc_dat_i   ),
  .loop_dat_i     (mix_dat     ),  // loopback source
  .digital_loop_i (digital_loop),
  .adc_dat_o      (adc_dat_o   )
);

dac_mixer #(.CH_N (CH_N)) dac_mixer_i (
  .asg_dat_i  (asg_dat_i),
  .pid_dat_i  (pid_dat_i),
  .mix_dat_o  (mix_dat  ),
  .sat_flag_o (sat_flag )
);

// Converter has two channels
dac_interleave dac_interleave_i (
  .dac_clk_1x (dac_clk_1x  ),
  .rst_i      (rst_i       ),
  .mix_dat_i  (mix_dat[1:0]),
  .dac_dat_o  (dac_dat_o   ),
  .dac_sel_o  (dac_sel_o   ),
  .dac_rst_o  (dac_rst_o   )
);

endmodule

//--- dac_interleave.sv
//////////////////////////////////////////////////////////////////////
// DAC output stage, two channels in offset code time multiplexed on
// one 14-bit bus with a select line and a registered DAC reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dac_interleave (
  input  logic                        dac_clk_1x,
  input  logic                        rst_i,
  input  afe_pkg::smp_t [1:0]         mix_dat_i,   // saturated mix
  output logic [afe_pkg::SMP_W-1:0]   dac_dat_o,   // multiplexed bus
  output logic                        dac_sel_o,   // 1 = channel 1
  output logic                        dac_rst_o
);

logic [afe_pkg::SMP_W-1:0] dac_dat_a;  // channel 0, offset code
logic [afe_pkg::SMP_W-1:0] dac_dat_b;  // channel 1, offset code

//////////////////////////////////////////////////////////////////////
// Stage 1, format
//////////////////////////////////////////////////////////////////////

always_ff @(posedge dac_clk_1x) begin
  dac_dat_a <= afe_pkg::neg_slope_conv(mix_dat_i[0]);
  dac_dat_b <= afe_pkg::neg_slope_conv(mix_dat_i[1]);
end

//////////////////////////////////////////////////////////////////////
// Stage 2, select and bus mux
//////////////////////////////////////////////////////////////////////

always_ff @(posedge dac_clk_1x) begin
  if (rst_i) begin
    dac_sel_o <= 1'b0;
    dac_dat_o <= '0;
  end else begin
    dac_sel_o <= ~dac_sel_o;                            // flips every cycle
    dac_dat_o <= ~dac_sel_o ? dac_dat_b : dac_dat_a;    // follows the new sel
  end
end

// Reset to the converter, one register late
always_ff @(posedge dac_clk_1x) begin
  dac_rst_o <= rst_i;
end

endmodule

//--- dac_mixer.sv
//////////////////////////////////////////////////////////////////////
// Per channel sum of generator and controller streams, saturated to
// the DAC range, combinational
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dac_mixer #(
  parameter int CH_N = 2
)(
  input  afe_pkg::smp_t [CH_N-1:0] asg_dat_i,   // generator
  input  afe_pkg::smp_t [CH_N-1:0] pid_dat_i,   // controller
  output afe_pkg::smp_t [CH_N-1:0] mix_dat_o,
  output logic [CH_N-1:0]          sat_flag_o   // channel was clamped
);

localparam int SW = afe_pkg::SUM_W;
localparam int DW = afe_pkg::SMP_W;

logic signed [SW-1:0] sum [CH_N];

//////////////////////////////////////////////////////////////////////
// Sum and clamp
//////////////////////////////////////////////////////////////////////

always_comb begin
  for (int i = 0; i < CH_N; i++) begin
    // Sign extended to the guard width
    sum[i] = SW'(asg_dat_i[i]) + SW'(pid_dat_i[i]);

    // Top two bits differ, result left the 14-bit range
    sat_flag_o[i] = sum[i][SW-1] ^ sum[i][SW-2];

    if (sat_flag_o[i])
      mix_dat_o[i] = {sum[i][SW-1], {(DW-1){~sum[i][SW-1]}}};  // full scale
    else
      mix_dat_o[i] = sum[i][DW-1:0];
  end
end

endmodule

//--- adc_frontend.sv
//////////////////////////////////////////////////////////////////////
// ADC input register, offset code to two's complement, loopback mux
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module adc_frontend #(
  parameter int CH_N = 2
)(
  input  logic                                     dac_clk_1x,
  input  logic                                     rst_i,
  input  logic [CH_N-1:0][afe_pkg::ADC_RAW_W-1:0]  adc_dat_i,      // pin words
  input  afe_pkg::smp_t [CH_N-1:0]                 loop_dat_i,     // DAC mix
  input  logic                                     digital_loop_i,
  output afe_pkg::smp_t [CH_N-1:0]                 adc_dat_o
);

logic [CH_N-1:0][afe_pkg::SMP_W-1:0] adc_raw;  // upper bits of each word

// Input register, the two LSBs are dropped
always_ff @(posedge dac_clk_1x) begin
  if (rst_i) begin
    adc_raw <= '0;
  end else begin
    for (int i = 0; i < CH_N; i++)
      adc_raw[i] <= adc_dat_i[i][afe_pkg::ADC_RAW_W-1 -: afe_pkg::SMP_W];
  end
end

// Per channel format and loopback select
always_comb begin
  for (int i = 0; i < CH_N; i++) begin
    if (digital_loop_i)
      adc_dat_o[i] = loop_dat_i[i];  // combinational from the mixer
    else
      adc_dat_o[i] = afe_pkg::neg_slope_conv(afe_pkg::smp_t'(adc_raw[i]));
  end
end

endmodule

//--- hk_regs.sv
//////////////////////////////////////////////////////////////////////
// Housekeeping registers behind a Wishbone classic slave port
// ID, loopback control and saturation event counter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module hk_regs #(
  parameter int CH_N = 2
)(
  input  logic                           dac_clk_1x,
  input  logic                           rst_i,
  // Wishbone slave
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  logic [hk_bus_pkg::WB_AW-1:0]   wb_adr_i,
  input  logic [hk_bus_pkg::WB_DW-1:0]   wb_dat_i,
  output logic [hk_bus_pkg::WB_DW-1:0]   wb_dat_o,
  output logic                           wb_ack_o,
  output logic                           wb_err_o,
  // Datapath status and control
  input  logic [CH_N-1:0]                sat_flag_i,   // one per channel
  output logic                           digital_loop_o
);

localparam int SNW = $clog2(CH_N + 1);  // popcount width

logic                           req;        // new request this cycle
logic                           adr_ok;     // address hits a register
logic [hk_bus_pkg::WB_DW-1:0]   rd_dat;
logic                           wr_ctrl;
logic                           wr_sat;
logic                           ctrl_loop;
logic [hk_bus_pkg::WB_DW-1:0]   sat_cnt;
logic [SNW-1:0]                 sat_num;    // flags set this cycle
logic [hk_bus_pkg::WB_DW:0]     cnt_sum;    // extra bit catches wrap

//////////////////////////////////////////////////////////////////////
// Address decode
//////////////////////////////////////////////////////////////////////

// Masked while answering, so a held stb is not served twice
assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;

always_comb begin
  adr_ok = 1'b1;
  rd_dat = '0;
  case (wb_adr_i)
    hk_bus_pkg::REG_ID:      rd_dat = hk_bus_pkg::ID_VALUE;
    hk_bus_pkg::REG_CTRL:    rd_dat[hk_bus_pkg::CTRL_LOOP_BIT] = ctrl_loop;
    hk_bus_pkg::REG_SAT_CNT: rd_dat = sat_cnt;
    default:                 adr_ok = 1'b0;  // unmapped, answer with err
  endcase
end

assign wr_ctrl = req & wb_we_i & (wb_adr_i == hk_bus_pkg::REG_CTRL);
assign wr_sat  = req & wb_we_i & (wb_adr_i == hk_bus_pkg::REG_SAT_CNT);

// Single-cycle answer, no wait states
always_ff @(posedge dac_clk_1x) begin
  if (rst_i) begin
    wb_ack_o <= 1'b0;
    wb_err_o <= 1'b0;
  end else begin
    wb_ack_o <= req &  adr_ok;
    wb_err_o <= req & ~adr_ok;
  end
end

// Read data captured with the request
always_ff @(posedge dac_clk_1x) begin
  if (req)
    wb_dat_o <= wb_we_i ? '0 : rd_dat;
end

//////////////////////////////////////////////////////////////////////
// Registers
//////////////////////////////////////////////////////////////////////

always_ff @(posedge dac_clk_1x) begin
  if (rst_i)
    ctrl_loop <= 1'b0;
  else if (wr_ctrl)
    ctrl_loop <= wb_dat_i[hk_bus_pkg::CTRL_LOOP_BIT];  // same edge as ack
end

assign digital_loop_o = ctrl_loop;

// Count of channels clamped this cycle
always_comb begin
  sat_num = '0;
  for (int i = 0; i < CH_N; i++)
    sat_num = sat_num + SNW'(sat_flag_i[i]);
end

assign cnt_sum = {1'b0, sat_cnt} + (hk_bus_pkg::WB_DW + 1)'(sat_num);

always_ff @(posedge dac_clk_1x) begin
  if (rst_i)
    sat_cnt <= '0;
  else if (wr_sat)
    sat_cnt <= '0;                       // clear wins over counting
  else if (cnt_sum[hk_bus_pkg::WB_DW])
    sat_cnt <= '1;                       // stick at all ones
  else
    sat_cnt <= cnt_sum[hk_bus_pkg::WB_DW-1:0];
end

endmodule

//--- hk_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// Housekeeping Wishbone bus widths, register map and CTRL bit layout
//////////////////////////////////////////////////////////////////////

package hk_bus_pkg;

  // Bus geometry, byte addresses
  localparam int WB_AW = 4;
  localparam int WB_DW = 32;

  // Register offsets
  localparam logic [WB_AW-1:0] REG_ID      = 4'h0;  // read-only ID
  localparam logic [WB_AW-1:0] REG_CTRL    = 4'h4;  // loopback control
  localparam logic [WB_AW-1:0] REG_SAT_CNT = 4'h8;  // saturation events

  // Identification word returned by REG_ID
  localparam logic [WB_DW-1:0] ID_VALUE = 32'hAFE0_0001;

  // CTRL bit positions
  localparam int CTRL_LOOP_BIT = 0;  // ADC fed from DAC path

endpackage

//--- afe_pkg.sv
//////////////////////////////////////////////////////////////////////
// Sample widths, sample type and offset-code conversion shared by
// the ADC and DAC datapath, referenced by scoped names
//////////////////////////////////////////////////////////////////////

package afe_pkg;

  // Pin and sample widths
  localparam int ADC_RAW_W = 16;   // ADC pin word, two LSBs unused
  localparam int SMP_W     = 14;   // converter resolution
  localparam int SUM_W     = 15;   // one guard bit for the stream sum

  // Board default, two analog channels
  localparam int CH_N_DEF  = 2;

  // Signed sample as seen by the processing cores
  typedef logic signed [SMP_W-1:0] smp_t;

  // Negative-slope offset code <-> two's complement
  // Sign bit kept, magnitude bits inverted, so the mapping is its own inverse
  function automatic smp_t neg_slope_conv(input smp_t smp);
    smp_t res;
    res = {smp[SMP_W-1], ~smp[SMP_W-2:0]};
    return res;
  endfunction

endpackage
